// ==== hdl/tlp_align_params.svh ====
// TLP aligner sizing macros for channel counts and per-slot field widths
`ifndef TLP_ALIGN_PARAMS_SVH
`define TLP_ALIGN_PARAMS_SVH

// Channel slots offered on each wide beat by the upstream source
`define TLP_IN_CH 4

// Channel slots carried on each beat by the downstream port
// It must divide TLP_IN_CH so that windows tile the wide beat evenly
`define TLP_OUT_CH 2

// Payload word carried in every slot
`define TLP_DATA_W 32

// Opcode field carried in every slot
// The opcode enum in the package is sized from this value
`define TLP_OP_W 2

// Only the narrowing case is built
// TLP_IN_CH is expected to be larger than TLP_OUT_CH and a power of two
// so that the chunk index wraps cleanly

`endif

// ==== hdl/tlp_align_pkg.sv ====
// TLP aligner package holding the opcode type carried in every channel slot
`include "tlp_align_params.svh"

package tlp_align_pkg;

    // Opcode tagged onto each slot of a beat
    // The aligner moves it along with the payload and never decodes it,
    // so the encoding only has to be stable end to end
    typedef enum logic [`TLP_OP_W-1:0]
    {
        // Memory read request
        op_mem_rd,

        // Memory write request with payload
        op_mem_wr,

        // Completion returned for an earlier read
        op_cpl,

        // Message without an address
        op_msg
    } tlp_op_e;

    // Cleared slots carry op_mem_rd since it encodes as all zeros

endpackage

// ==== hdl/tx_tlp_packer.sv ====
// TLP packer that moves the valid slots of each wide beat into the low channels
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tx_tlp_packer
    import tlp_align_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset_n,

    // Wide beat from the upstream source
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic                                  in_last,
    input  logic [`TLP_IN_CH-1:0]                 in_ch_valid,
    input  logic [`TLP_IN_CH-1:0]                 in_ch_sop,
    input  logic [`TLP_IN_CH-1:0]                 in_ch_eop,
    input  tlp_op_e [`TLP_IN_CH-1:0]              in_ch_op,
    input  logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] in_ch_data,

    // Packed wide beat toward the skid buffer
    output logic                                  pk_valid,
    input  logic                                  pk_ready,
    output logic                                  pk_last,
    output logic [`TLP_IN_CH-1:0]                 pk_ch_valid,
    output logic [`TLP_IN_CH-1:0]                 pk_ch_sop,
    output logic [`TLP_IN_CH-1:0]                 pk_ch_eop,
    output tlp_op_e [`TLP_IN_CH-1:0]              pk_ch_op,
    output logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] pk_ch_data
);

    // Compacted version of the incoming beat before the output register
    logic [`TLP_IN_CH-1:0]                  pack_valid;
    logic [`TLP_IN_CH-1:0]                  pack_sop;
    logic [`TLP_IN_CH-1:0]                  pack_eop;
    tlp_op_e [`TLP_IN_CH-1:0]               pack_op;
    logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] pack_data;

    // Each valid slot lands at the channel given by the number of valid
    // slots below it, so the order of slots is kept
    always_comb
    begin
        int dst;

        // Unused upper channels end up invalid with sop and eop low
        for (int c = 0; c < `TLP_IN_CH; c++)
        begin
            pack_valid[c] = 1'b0;
            pack_sop[c]   = 1'b0;
            pack_eop[c]   = 1'b0;
            pack_op[c]    = op_mem_rd;
            pack_data[c]  = '0;
        end

        dst = 0;
        for (int i = 0; i < `TLP_IN_CH; i++)
        begin
            if (in_ch_valid[i])
            begin
                pack_valid[dst] = 1'b1;
                pack_sop[dst]   = in_ch_sop[i];
                pack_eop[dst]   = in_ch_eop[i];
                pack_op[dst]    = in_ch_op[i];
                pack_data[dst]  = in_ch_data[i];
                dst = dst + 1;
            end
        end
    end

    // Single output register, free when empty or drained in this cycle
    assign in_ready = !pk_valid || pk_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pk_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            pk_valid <= in_valid;
        end
    end

    // Payload only moves on an accepted beat and holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            pk_last     <= in_last;
            pk_ch_valid <= pack_valid;
            pk_ch_sop   <= pack_sop;
            pk_ch_eop   <= pack_eop;
            pk_ch_op    <= pack_op;
            pk_ch_data  <= pack_data;
        end
    end

endmodule

// ==== hdl/tx_skid_buffer.sv ====
// Two-entry skid buffer for the packed wide beat with a registered upstream ready
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tx_skid_buffer
    import tlp_align_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset_n,

    // Packed beat from the packer
    input  logic                                  sk_in_valid,
    output logic                                  sk_in_ready,
    input  logic                                  sk_in_last,
    input  logic [`TLP_IN_CH-1:0]                 sk_in_ch_valid,
    input  logic [`TLP_IN_CH-1:0]                 sk_in_ch_sop,
    input  logic [`TLP_IN_CH-1:0]                 sk_in_ch_eop,
    input  tlp_op_e [`TLP_IN_CH-1:0]              sk_in_ch_op,
    input  logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] sk_in_ch_data,

    // Head entry toward the narrower
    output logic                                  sk_valid,
    input  logic                                  sk_ready,
    output logic                                  sk_last,
    output logic [`TLP_IN_CH-1:0]                 sk_ch_valid,
    output logic [`TLP_IN_CH-1:0]                 sk_ch_sop,
    output logic [`TLP_IN_CH-1:0]                 sk_ch_eop,
    output tlp_op_e [`TLP_IN_CH-1:0]              sk_ch_op,
    output logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] sk_ch_data
);

    // Second entry catches the beat that arrives while ready is still high
    logic                                   skid_full;
    logic                                   skid_last;
    logic [`TLP_IN_CH-1:0]                  skid_ch_valid;
    logic [`TLP_IN_CH-1:0]                  skid_ch_sop;
    logic [`TLP_IN_CH-1:0]                  skid_ch_eop;
    tlp_op_e [`TLP_IN_CH-1:0]               skid_ch_op;
    logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] skid_ch_data;

    logic accept;
    logic pop;
    logic main_full_n;
    logic skid_full_n;

    assign accept = sk_in_valid && sk_in_ready;
    assign pop    = sk_valid && sk_ready;

    // Occupancy for the next cycle
    // Ready is only high below two entries, so an accept never finds the skid full
    always_comb
    begin
        main_full_n = sk_valid;
        skid_full_n = skid_full;
        if (accept && !pop)
        begin
            if (sk_valid)
            begin
                skid_full_n = 1'b1;
            end
            else
            begin
                main_full_n = 1'b1;
            end
        end
        else if (!accept && pop)
        begin
            if (skid_full)
            begin
                skid_full_n = 1'b0;
            end
            else
            begin
                main_full_n = 1'b0;
            end
        end
    end

    // Ready comes straight from a flop so no combinational path runs upstream
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sk_valid    <= 1'b0;
            skid_full   <= 1'b0;
            sk_in_ready <= 1'b1;
        end
        else
        begin
            sk_valid    <= main_full_n;
            skid_full   <= skid_full_n;
            sk_in_ready <= !(main_full_n && skid_full_n);
        end
    end

    // Head refills from the skid first so beat order is kept
    always_ff @(posedge clk)
    begin
        if (pop && skid_full)
        begin
            sk_last     <= skid_last;
            sk_ch_valid <= skid_ch_valid;
            sk_ch_sop   <= skid_ch_sop;
            sk_ch_eop   <= skid_ch_eop;
            sk_ch_op    <= skid_ch_op;
            sk_ch_data  <= skid_ch_data;
        end
        else if (accept && (pop || !sk_valid))
        begin
            sk_last     <= sk_in_last;
            sk_ch_valid <= sk_in_ch_valid;
            sk_ch_sop   <= sk_in_ch_sop;
            sk_ch_eop   <= sk_in_ch_eop;
            sk_ch_op    <= sk_in_ch_op;
            sk_ch_data  <= sk_in_ch_data;
        end

        // Consumer stalled with the head occupied
        if (accept && sk_valid && !pop)
        begin
            skid_last     <= sk_in_last;
            skid_ch_valid <= sk_in_ch_valid;
            skid_ch_sop   <= sk_in_ch_sop;
            skid_ch_eop   <= sk_in_ch_eop;
            skid_ch_op    <= sk_in_ch_op;
            skid_ch_data  <= sk_in_ch_data;
        end
    end

endmodule

// ==== hdl/tx_tlp_narrower.sv ====
// TLP narrower that splits each packed wide beat into output-width chunks
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tx_tlp_narrower
    import tlp_align_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset_n,

    // Packed wide beat from the skid buffer
    input  logic                                   sk_valid,
    output logic                                   sk_ready,
    input  logic                                   sk_last,
    input  logic [`TLP_IN_CH-1:0]                  sk_ch_valid,
    input  logic [`TLP_IN_CH-1:0]                  sk_ch_sop,
    input  logic [`TLP_IN_CH-1:0]                  sk_ch_eop,
    input  tlp_op_e [`TLP_IN_CH-1:0]               sk_ch_op,
    input  logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0]  sk_ch_data,

    // Narrow beat toward the downstream port
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   out_last,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_valid,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_sop,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_eop,
    output tlp_op_e [`TLP_OUT_CH-1:0]              out_ch_op,
    output logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] out_ch_data
);

    localparam int IDX_W = $clog2(`TLP_IN_CH);

    // First input slot of the window sent in the current chunk
    logic [IDX_W-1:0] chan_idx;

    // Some valid slot sits above the current window
    logic more_above;

    // Output register can take a new chunk
    logic out_adv;

    // Window of slots selected for the next chunk
    logic [`TLP_OUT_CH-1:0]                  win_valid;
    logic [`TLP_OUT_CH-1:0]                  win_sop;
    logic [`TLP_OUT_CH-1:0]                  win_eop;
    tlp_op_e [`TLP_OUT_CH-1:0]               win_op;
    logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] win_data;

    // Slots are densely packed, so a valid slot past the window means
    // at least one more chunk is owed for this beat
    always_comb
    begin
        more_above = 1'b0;
        for (int c = 0; c < `TLP_IN_CH; c++)
        begin
            if (c >= int'(chan_idx) + `TLP_OUT_CH)
            begin
                more_above = more_above || sk_ch_valid[c];
            end
        end
    end

    // Select the slots starting at the chunk index
    always_comb
    begin
        int src;

        for (int i = 0; i < `TLP_OUT_CH; i++)
        begin
            src = i + int'(chan_idx);
            if (src < `TLP_IN_CH)
            begin
                win_valid[i] = sk_ch_valid[src];
                win_sop[i]   = sk_ch_sop[src];
                win_eop[i]   = sk_ch_eop[src];
                win_op[i]    = sk_ch_op[src];
                win_data[i]  = sk_ch_data[src];
            end
            else
            begin
                // Past the input width there is nothing to forward
                win_valid[i] = 1'b0;
                win_sop[i]   = 1'b0;
                win_eop[i]   = 1'b0;
                win_op[i]    = op_mem_rd;
                win_data[i]  = '0;
            end
        end
    end

    assign out_adv = out_ready || !out_valid;

    // The wide beat is released only together with its final chunk
    assign sk_ready = out_adv && !more_above;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            chan_idx     <= '0;
            out_valid    <= 1'b0;
            out_last     <= 1'b0;
            out_ch_valid <= '0;
        end
        else if (out_adv)
        begin
            out_valid <= sk_valid;
            out_last  <= sk_valid && sk_last && !more_above;
            if (sk_valid)
            begin
                out_ch_valid <= win_valid;
            end

            // Step to the next window or start over on the next beat
            if (sk_valid && more_above)
            begin
                chan_idx <= chan_idx + IDX_W'(`TLP_OUT_CH);
            end
            else
            begin
                chan_idx <= '0;
            end
        end
    end

    // Chunk payload follows the valid bits and holds while stalled
    always_ff @(posedge clk)
    begin
        if (out_adv && sk_valid)
        begin
            out_ch_sop  <= win_sop;
            out_ch_eop  <= win_eop;
            out_ch_op   <= win_op;
            out_ch_data <= win_data;
        end
    end

endmodule

// ==== hdl/tx_tlp_align_top.sv ====
// TLP transmit aligner chaining the packer, skid buffer and narrower
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tx_tlp_align_top
    import tlp_align_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset_n,

    // Wide beat from the host channel source
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic                                   in_last,
    input  logic [`TLP_IN_CH-1:0]                  in_ch_valid,
    input  logic [`TLP_IN_CH-1:0]                  in_ch_sop,
    input  logic [`TLP_IN_CH-1:0]                  in_ch_eop,
    input  tlp_op_e [`TLP_IN_CH-1:0]               in_ch_op,
    input  logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0]  in_ch_data,

    // Narrow beat to the downstream port
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic                                   out_last,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_valid,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_sop,
    output logic [`TLP_OUT_CH-1:0]                 out_ch_eop,
    output tlp_op_e [`TLP_OUT_CH-1:0]              out_ch_op,
    output logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] out_ch_data
);

    // Packer to skid buffer
    logic                                   pk_valid;
    logic                                   pk_ready;
    logic                                   pk_last;
    logic [`TLP_IN_CH-1:0]                  pk_ch_valid;
    logic [`TLP_IN_CH-1:0]                  pk_ch_sop;
    logic [`TLP_IN_CH-1:0]                  pk_ch_eop;
    tlp_op_e [`TLP_IN_CH-1:0]               pk_ch_op;
    logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] pk_ch_data;

    // Skid buffer to narrower
    logic                                   sk_valid;
    logic                                   sk_ready;
    logic                                   sk_last;
    logic [`TLP_IN_CH-1:0]                  sk_ch_valid;
    logic [`TLP_IN_CH-1:0]                  sk_ch_sop;
    logic [`TLP_IN_CH-1:0]                  sk_ch_eop;
    tlp_op_e [`TLP_IN_CH-1:0]               sk_ch_op;
    logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] sk_ch_data;

    // Producer packs valid slots low, which the narrower depends on
    tx_tlp_packer u_packer
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_last     (in_last),
        .in_ch_valid (in_ch_valid),
        .in_ch_sop   (in_ch_sop),
        .in_ch_eop   (in_ch_eop),
        .in_ch_op    (in_ch_op),
        .in_ch_data  (in_ch_data),
        .pk_valid    (pk_valid),
        .pk_ready    (pk_ready),
        .pk_last     (pk_last),
        .pk_ch_valid (pk_ch_valid),
        .pk_ch_sop   (pk_ch_sop),
        .pk_ch_eop   (pk_ch_eop),
        .pk_ch_op    (pk_ch_op),
        .pk_ch_data  (pk_ch_data)
    );

    // Timing stage between the two halves
    tx_skid_buffer u_skid
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .sk_in_valid    (pk_valid),
        .sk_in_ready    (pk_ready),
        .sk_in_last     (pk_last),
        .sk_in_ch_valid (pk_ch_valid),
        .sk_in_ch_sop   (pk_ch_sop),
        .sk_in_ch_eop   (pk_ch_eop),
        .sk_in_ch_op    (pk_ch_op),
        .sk_in_ch_data  (pk_ch_data),
        .sk_valid       (sk_valid),
        .sk_ready       (sk_ready),
        .sk_last        (sk_last),
        .sk_ch_valid    (sk_ch_valid),
        .sk_ch_sop      (sk_ch_sop),
        .sk_ch_eop      (sk_ch_eop),
        .sk_ch_op       (sk_ch_op),
        .sk_ch_data     (sk_ch_data)
    );

    // Consumer cuts each wide beat into narrow chunks
    tx_tlp_narrower u_narrower
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .sk_valid     (sk_valid),
        .sk_ready     (sk_ready),
        .sk_last      (sk_last),
        .sk_ch_valid  (sk_ch_valid),
        .sk_ch_sop    (sk_ch_sop),
        .sk_ch_eop    (sk_ch_eop),
        .sk_ch_op     (sk_ch_op),
        .sk_ch_data   (sk_ch_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_ch_valid (out_ch_valid),
        .out_ch_sop   (out_ch_sop),
        .out_ch_eop   (out_ch_eop),
        .out_ch_op    (out_ch_op),
        .out_ch_data  (out_ch_data)
    );

endmodule

// ==== testbench/tx_tlp_align_checker.sv ====
// Output protocol checker for the TLP aligner top level, attached with bind
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tx_tlp_align_checker
    import tlp_align_pkg::*;
(
    input logic                                   clk,
    input logic                                   reset_n,
    input logic                                   out_valid,
    input logic                                   out_ready,
    input logic                                   out_last,
    input logic [`TLP_OUT_CH-1:0]                 out_ch_valid,
    input logic [`TLP_OUT_CH-1:0]                 out_ch_sop,
    input logic [`TLP_OUT_CH-1:0]                 out_ch_eop,
    input tlp_op_e [`TLP_OUT_CH-1:0]              out_ch_op,
    input logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] out_ch_data
);

    // A dense mask has the form 2^n - 1, so adding one leaves no bit in common
    logic [`TLP_OUT_CH-1:0] valid_plus_one;

    assign valid_plus_one = out_ch_valid + {{(`TLP_OUT_CH-1){1'b0}}, 1'b1};

    // Synchronous reset must leave the output idle on the following cycle
    reset_clears_valid: assert property (@(posedge clk) !reset_n |=> !out_valid)
        else $error("out_valid was high in the cycle after reset");

    // A stalled beat has to be presented again unchanged
    stall_holds_beat: assert property (@(posedge clk) disable iff (!reset_n)
        (out_valid && !out_ready) |=> ($stable(out_valid) && $stable(out_last)
        && $stable(out_ch_valid) && $stable(out_ch_sop) && $stable(out_ch_eop)
        && $stable(out_ch_op) && $stable(out_ch_data)))
        else $error("output beat changed while stalled by out_ready");

    // The packer guarantees compaction, so no gap may appear in a chunk
    dense_slots: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> ((out_ch_valid & valid_plus_one) == '0))
        else $error("out_ch_valid has a high slot above a low slot");

    // last only qualifies a real beat
    last_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
        out_last |-> out_valid)
        else $error("out_last was high without out_valid");

endmodule

// ==== testbench/tb_tx_tlp_align.sv ====
// Table-driven testbench for the TLP transmit aligner with a reference model
`timescale 1ns/1ps
`include "tlp_align_params.svh"

module tb_tx_tlp_align
    import tlp_align_pkg::*;
();

    localparam int NUM_TESTS      = 8;
    localparam int TIMEOUT_CYCLES = 200;

    // One row of the stimulus table
    typedef struct {
        string                                  name;
        logic [`TLP_IN_CH-1:0]                  mask;
        logic [`TLP_IN_CH-1:0]                  sop;
        logic [`TLP_IN_CH-1:0]                  eop;
        tlp_op_e [`TLP_IN_CH-1:0]               op;
        logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] data;
        logic                                   last;
        logic                                   stall;
    } test_row_t;

    // One narrow beat predicted by the reference model
    typedef struct {
        string                                   name;
        logic                                    last;
        logic [`TLP_OUT_CH-1:0]                  chv;
        logic [`TLP_OUT_CH-1:0]                  sop;
        logic [`TLP_OUT_CH-1:0]                  eop;
        tlp_op_e [`TLP_OUT_CH-1:0]               op;
        logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] data;
    } exp_beat_t;

    logic                                    clk;
    logic                                    reset_n;
    logic                                    in_valid;
    logic                                    in_ready;
    logic                                    in_last;
    logic [`TLP_IN_CH-1:0]                   in_ch_valid;
    logic [`TLP_IN_CH-1:0]                   in_ch_sop;
    logic [`TLP_IN_CH-1:0]                   in_ch_eop;
    tlp_op_e [`TLP_IN_CH-1:0]                in_ch_op;
    logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0]  in_ch_data;
    logic                                    out_valid;
    logic                                    out_ready;
    logic                                    out_last;
    logic [`TLP_OUT_CH-1:0]                  out_ch_valid;
    logic [`TLP_OUT_CH-1:0]                  out_ch_sop;
    logic [`TLP_OUT_CH-1:0]                  out_ch_eop;
    tlp_op_e [`TLP_OUT_CH-1:0]               out_ch_op;
    logic [`TLP_OUT_CH-1:0][`TLP_DATA_W-1:0] out_ch_data;

    test_row_t   tests [NUM_TESTS];
    exp_beat_t   exp_q [$];
    logic        stall_en;
    int unsigned rand_seed;
    int          errors     = 0;
    int          timeouts   = 0;
    int          beats_seen = 0;

    tx_tlp_align_top dut
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .in_ch_valid  (in_ch_valid),
        .in_ch_sop    (in_ch_sop),
        .in_ch_eop    (in_ch_eop),
        .in_ch_op     (in_ch_op),
        .in_ch_data   (in_ch_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_ch_valid (out_ch_valid),
        .out_ch_sop   (out_ch_sop),
        .out_ch_eop   (out_ch_eop),
        .out_ch_op    (out_ch_op),
        .out_ch_data  (out_ch_data)
    );

    // Protocol assertions sit on the output port of every top level instance
    bind tx_tlp_align_top tx_tlp_align_checker u_checker
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_ch_valid (out_ch_valid),
        .out_ch_sop   (out_ch_sop),
        .out_ch_eop   (out_ch_eop),
        .out_ch_op    (out_ch_op),
        .out_ch_data  (out_ch_data)
    );

    // 100 ns clock
    always
    begin
        #50 clk = ~clk;
    end

    // Downstream ready is pulled low about a third of the time in stall phases
    // The stall phase is taken at the edge, so a phase change made 1 ns later
    // applies from the following cycle
    always @(posedge clk)
    begin
        logic stall_now;
        stall_now = stall_en;
        #1;
        if (stall_now)
        begin
            out_ready = ($urandom % 3) != 0;
        end
        else
        begin
            out_ready = 1'b1;
        end
    end

    task automatic set_row(input int idx, input string name, input logic [3:0] mask,
                           input logic [3:0] sop, input logic [3:0] eop,
                           input logic last, input logic stall);
        tests[idx].name  = name;
        tests[idx].mask  = mask;
        tests[idx].sop   = sop;
        tests[idx].eop   = eop;
        tests[idx].last  = last;
        tests[idx].stall = stall;
        // Invalid slots carry words too, so a leak into the output shows up
        for (int s = 0; s < `TLP_IN_CH; s++)
        begin
            tests[idx].op[s]   = tlp_op_e'(2'((idx + s) % 4));
            tests[idx].data[s] = 32'hc0de_0000 | 32'(idx * 256 + s);
        end
    endtask

    // Stray sop and eop bits on masked-off slots must be dropped
    task automatic load_table();
        set_row(0, "full_last",    4'b1111, 4'b0001, 4'b1000, 1'b1, 1'b0);
        set_row(1, "sparse_13",    4'b1010, 4'b0011, 4'b1000, 1'b0, 1'b0);
        set_row(2, "sparse_2",     4'b0100, 4'b1101, 4'b0100, 1'b1, 1'b0);
        set_row(3, "empty_last",   4'b0000, 4'b1111, 4'b0110, 1'b1, 1'b0);
        set_row(4, "three_stall",  4'b0111, 4'b0001, 4'b0100, 1'b1, 1'b1);
        set_row(5, "full_stall",   4'b1111, 4'b0101, 4'b1010, 1'b0, 1'b1);
        set_row(6, "sparse_03",    4'b1001, 4'b1001, 4'b1001, 1'b1, 1'b1);
        set_row(7, "empty_stall",  4'b0000, 4'b0000, 4'b0000, 1'b0, 1'b1);
    endtask

    // The reference model compacts the slots, cuts them into windows and
    // flags last on the final one
    function automatic void build_expected(input int idx);
        logic [`TLP_IN_CH-1:0]                  cv;
        logic [`TLP_IN_CH-1:0]                  cs;
        logic [`TLP_IN_CH-1:0]                  ce;
        tlp_op_e [`TLP_IN_CH-1:0]               co;
        logic [`TLP_IN_CH-1:0][`TLP_DATA_W-1:0] cd;
        exp_beat_t                              b;
        int                                     k;
        int                                     nwin;
        cv = '0;
        cs = '0;
        ce = '0;
        co = '0;
        cd = '0;
        k  = 0;
        for (int s = 0; s < `TLP_IN_CH; s++)
        begin
            if (tests[idx].mask[s])
            begin
                cv[k] = 1'b1;
                cs[k] = tests[idx].sop[s];
                ce[k] = tests[idx].eop[s];
                co[k] = tests[idx].op[s];
                cd[k] = tests[idx].data[s];
                k++;
            end
        end
        // An empty beat still produces one all-invalid window
        nwin = (k + `TLP_OUT_CH - 1) / `TLP_OUT_CH;
        if (nwin == 0)
        begin
            nwin = 1;
        end
        for (int w = 0; w < nwin; w++)
        begin
            b.name = tests[idx].name;
            b.last = tests[idx].last && (w == nwin - 1);
            for (int c = 0; c < `TLP_OUT_CH; c++)
            begin
                b.chv[c]  = cv[w * `TLP_OUT_CH + c];
                b.sop[c]  = cs[w * `TLP_OUT_CH + c];
                b.eop[c]  = ce[w * `TLP_OUT_CH + c];
                b.op[c]   = co[w * `TLP_OUT_CH + c];
                b.data[c] = cd[w * `TLP_OUT_CH + c];
            end
            exp_q.push_back(b);
        end
    endfunction

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] expv, input logic [31:0] actv);
        errors++;
        $display("ERR %s %s expected %0h actual %0h", test, field, expv, actv);
    endtask

    // Opcode and payload only matter on valid slots
    task automatic check_beat(input exp_beat_t head);
        assert (out_last === head.last)
            else report_mismatch(head.name, "last", 32'(head.last), 32'(out_last));
        assert (out_ch_valid === head.chv)
            else report_mismatch(head.name, "ch_valid", 32'(head.chv), 32'(out_ch_valid));
        assert (out_ch_sop === head.sop)
            else report_mismatch(head.name, "ch_sop", 32'(head.sop), 32'(out_ch_sop));
        assert (out_ch_eop === head.eop)
            else report_mismatch(head.name, "ch_eop", 32'(head.eop), 32'(out_ch_eop));
        for (int c = 0; c < `TLP_OUT_CH; c++)
        begin
            if (head.chv[c])
            begin
                assert (out_ch_op[c] === head.op[c])
                    else report_mismatch(head.name, $sformatf("op[%0d]", c),
                                         32'(head.op[c]), 32'(out_ch_op[c]));
                assert (out_ch_data[c] === head.data[c])
                    else report_mismatch(head.name, $sformatf("data[%0d]", c),
                                         head.data[c], out_ch_data[c]);
            end
        end
    endtask

    // Every accepted output beat is matched against the queue head
    always @(posedge clk)
    begin
        exp_beat_t head;
        if (reset_n && out_valid && out_ready)
        begin
            beats_seen++;
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("Output beat arrived while no beat was expected");
            end
            if (exp_q.size() != 0)
            begin
                head = exp_q.pop_front();
                check_beat(head);
            end
        end
    end

    // Offer one table row and hold it until the input takes it
    task automatic send_entry(input int idx);
        int   waited;
        logic accepted;
        build_expected(idx);
        stall_en    = tests[idx].stall;
        in_valid    = 1'b1;
        in_last     = tests[idx].last;
        in_ch_valid = tests[idx].mask;
        in_ch_sop   = tests[idx].sop;
        in_ch_eop   = tests[idx].eop;
        in_ch_op    = tests[idx].op;
        in_ch_data  = tests[idx].data;
        accepted    = 1'b0;
        waited      = 0;
        while (!accepted && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end
        #1;
        in_valid = 1'b0;
        assert (accepted)
        else
        begin
            timeouts++;
            $display("Timeout: input did not accept test %s within %0d cycles",
                     tests[idx].name, TIMEOUT_CYCLES);
        end
    endtask

    initial
    begin
        int waited;
        rand_seed   = $urandom(32'h3b10);
        clk         = 1'b0;
        reset_n     = 1'b0;
        in_valid    = 1'b0;
        in_last     = 1'b0;
        in_ch_valid = '0;
        in_ch_sop   = '0;
        in_ch_eop   = '0;
        in_ch_op    = '0;
        in_ch_data  = '0;
        out_ready   = 1'b1;
        stall_en    = 1'b0;
        load_table();

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        assert (out_valid === 1'b0)
        else
        begin
            errors++;
            $display("Output valid was high right after reset");
        end

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            send_entry(t);
        end

        // Let the pipeline empty with the port always ready
        stall_en = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            timeouts++;
            $display("Timeout: %0d expected output beats never arrived", exp_q.size());
        end
        // A few idle cycles so a spurious extra beat is still caught
        repeat (4) @(posedge clk);
        #1;

        $display("Summary: %0d value errors, %0d timeouts, %0d beats checked",
                 errors, timeouts, beats_seen);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/tlp_align_pkg.sv
hdl/tx_tlp_packer.sv
hdl/tx_skid_buffer.sv
hdl/tx_tlp_narrower.sv
hdl/tx_tlp_align_top.sv
testbench/tx_tlp_align_checker.sv
testbench/tb_tx_tlp_align.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TLP aligner testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_tx_tlp_align \
    -o Vtb_tx_tlp_align

# A stop from a failing concurrent assertion also ends the script here
./obj_dir/Vtb_tx_tlp_align | tee sim.log

if grep -q "Simulation failed" sim.log
then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0
